// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

	localparam int xlen = 32;
	localparam logic [xlen-1:0] reset_pc = '0;
	localparam int reg_count = 32;

	// Primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_jal   = 6'h03,
		op_beq   = 6'h04,
		op_addiu = 6'h09,
		op_ori   = 6'h0d,
		op_lui   = 6'h0f,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_t;

	// R-type function field, bits 5:0
	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_jr   = 6'h08,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_slt  = 6'h2a
	} funct_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_sll,
		alu_lui
	} alu_op_t;

	// Decode operand source, youngest producer wins
	typedef enum logic [1:0] {
		fwd_reg,
		fwd_ex,
		fwd_mem,
		fwd_wb
	} fwd_sel_t;

endpackage

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  cpu_pkg::alu_op_t op,
	input  logic [cpu_pkg::xlen-1:0] a,
	input  logic [cpu_pkg::xlen-1:0] b,
	input  logic [4:0] shamt,
	output logic [cpu_pkg::xlen-1:0] result,
	output logic zero
);

	always_comb begin
		case (op)
			cpu_pkg::alu_add: result = a + b;
			cpu_pkg::alu_sub: result = a - b;
			cpu_pkg::alu_and: result = a & b;
			cpu_pkg::alu_or:  result = a | b;
			// Signed compare, result is 0 or 1
			cpu_pkg::alu_slt: result = {{(cpu_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
			// sll shifts the rt operand
			cpu_pkg::alu_sll: result = b << shamt;
			cpu_pkg::alu_lui: result = b << 16;
			default:          result = '0;
		endcase
	end

	// beq uses this after a subtract
	assign zero = (result == '0);

endmodule

// ==== hw/control.sv ====
`timescale 1ns/1ps

module control (
	input  logic [5:0] opcode,
	input  logic [5:0] funct,
	output logic reg_write,
	output logic reg_dst,
	output logic alu_src,
	output logic mem_read,
	output logic mem_write,
	output logic mem_to_reg,
	output logic is_branch,
	output logic is_jump,
	output logic jump_reg,
	output logic is_link,
	output cpu_pkg::alu_op_t alu_op
);

	always_comb begin
		// Anything not listed below falls through as a no-op
		reg_write = 1'b0;
		reg_dst = 1'b0;
		alu_src = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_to_reg = 1'b0;
		is_branch = 1'b0;
		is_jump = 1'b0;
		jump_reg = 1'b0;
		is_link = 1'b0;
		alu_op = cpu_pkg::alu_add;
		case (opcode)
			cpu_pkg::op_rtype: begin
				reg_dst = 1'b1;
				reg_write = 1'b1;
				case (funct)
					cpu_pkg::fn_addu: alu_op = cpu_pkg::alu_add;
					cpu_pkg::fn_subu: alu_op = cpu_pkg::alu_sub;
					cpu_pkg::fn_and:  alu_op = cpu_pkg::alu_and;
					cpu_pkg::fn_or:   alu_op = cpu_pkg::alu_or;
					cpu_pkg::fn_slt:  alu_op = cpu_pkg::alu_slt;
					cpu_pkg::fn_sll:  alu_op = cpu_pkg::alu_sll;
					cpu_pkg::fn_jr: begin
						reg_write = 1'b0;
						is_jump = 1'b1;
						jump_reg = 1'b1;
					end
					default: reg_write = 1'b0;
				endcase
			end
			cpu_pkg::op_j: is_jump = 1'b1;
			cpu_pkg::op_jal: begin
				is_jump = 1'b1;
				is_link = 1'b1;
				reg_write = 1'b1;
			end
			// Compare by subtraction, taken on zero
			cpu_pkg::op_beq: begin
				is_branch = 1'b1;
				alu_op = cpu_pkg::alu_sub;
			end
			cpu_pkg::op_addiu: begin
				reg_write = 1'b1;
				alu_src = 1'b1;
			end
			cpu_pkg::op_ori: begin
				reg_write = 1'b1;
				alu_src = 1'b1;
				alu_op = cpu_pkg::alu_or;
			end
			cpu_pkg::op_lui: begin
				reg_write = 1'b1;
				alu_src = 1'b1;
				alu_op = cpu_pkg::alu_lui;
			end
			cpu_pkg::op_lw: begin
				reg_write = 1'b1;
				alu_src = 1'b1;
				mem_read = 1'b1;
				mem_to_reg = 1'b1;
			end
			cpu_pkg::op_sw: begin
				alu_src = 1'b1;
				mem_write = 1'b1;
			end
			default: is_jump = 1'b0;
		endcase
	end

endmodule

// ==== hw/regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input  logic clk,
	input  logic rst,
	input  logic [$clog2(cpu_pkg::reg_count)-1:0] rs_addr,
	input  logic [$clog2(cpu_pkg::reg_count)-1:0] rt_addr,
	output logic [cpu_pkg::xlen-1:0] rs_data,
	output logic [cpu_pkg::xlen-1:0] rt_data,
	input  logic wr_en,
	input  logic [$clog2(cpu_pkg::reg_count)-1:0] wr_addr,
	input  logic [cpu_pkg::xlen-1:0] wr_data
);

	logic [cpu_pkg::xlen-1:0] regs [cpu_pkg::reg_count];

	// Register zero reads zero, a same-cycle write shows through
	function automatic logic [cpu_pkg::xlen-1:0] read_port(
		input logic [$clog2(cpu_pkg::reg_count)-1:0] addr
	);
		if (addr == '0)
			return '0;
		if (wr_en && wr_addr == addr)
			return wr_data;
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cpu_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	always_comb begin
		rs_data = read_port(rs_addr);
		rt_data = read_port(rt_addr);
	end

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
	input  logic [$clog2(cpu_pkg::reg_count)-1:0] id_rs,
	input  logic [$clog2(cpu_pkg::reg_count)-1:0] id_rt,
	input  logic [$clog2(cpu_pkg::reg_count)-1:0] ex_dst,
	input  logic [$clog2(cpu_pkg::reg_count)-1:0] mem_dst,
	input  logic [$clog2(cpu_pkg::reg_count)-1:0] wb_dst,
	input  logic ex_reg_write,
	input  logic mem_reg_write,
	input  logic wb_reg_write,
	input  logic ex_mem_read,
	output cpu_pkg::fwd_sel_t fwd_rs,
	output cpu_pkg::fwd_sel_t fwd_rt,
	output logic load_stall
);

	// Youngest writer first, register zero never forwards
	function automatic cpu_pkg::fwd_sel_t pick(
		input logic [$clog2(cpu_pkg::reg_count)-1:0] src
	);
		if (src == '0)
			return cpu_pkg::fwd_reg;
		if (ex_reg_write && ex_dst == src)
			return cpu_pkg::fwd_ex;
		if (mem_reg_write && mem_dst == src)
			return cpu_pkg::fwd_mem;
		if (wb_reg_write && wb_dst == src)
			return cpu_pkg::fwd_wb;
		return cpu_pkg::fwd_reg;
	endfunction

	always_comb begin
		fwd_rs = pick(id_rs);
		fwd_rt = pick(id_rt);
	end

	// Load data exists only after the memory stage
	assign load_stall = ex_mem_read && ex_dst != '0 && (ex_dst == id_rs || ex_dst == id_rt);

endmodule

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
	input  logic clk,
	input  logic rst,
	// Fetch channel, read only
	input  logic if_req,
	input  logic [cpu_pkg::xlen-1:0] if_addr,
	output logic if_ack,
	output logic [cpu_pkg::xlen-1:0] if_rdata,
	// Data channel
	input  logic dm_req,
	input  logic dm_rw,
	input  logic [cpu_pkg::xlen-1:0] dm_addr,
	input  logic [cpu_pkg::xlen-1:0] dm_wdata,
	output logic dm_ack,
	output logic [cpu_pkg::xlen-1:0] dm_rdata,
	// External port
	output logic mem_enable,
	output logic mem_rw,
	output logic [cpu_pkg::xlen-1:0] mem_addr,
	output logic [cpu_pkg::xlen-1:0] mem_wdata,
	input  logic mem_ack,
	input  logic [cpu_pkg::xlen-1:0] mem_rdata
);

	logic busy;
	logic owner_dm;
	logic sel_dm;

	// Idle port grants at once, data over fetch
	assign sel_dm = busy ? owner_dm : dm_req;

	assign mem_enable = busy | dm_req | if_req;
	assign mem_rw = sel_dm ? dm_rw : 1'b1;
	assign mem_addr = sel_dm ? dm_addr : if_addr;
	assign mem_wdata = sel_dm ? dm_wdata : '0;

	assign dm_ack = mem_ack & sel_dm;
	assign if_ack = mem_ack & ~sel_dm;
	assign dm_rdata = mem_rdata;
	assign if_rdata = mem_rdata;

	// Owner is locked from grant until mem_ack
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			owner_dm <= 1'b0;
		end else if (mem_ack) begin
			busy <= 1'b0;
		end else if (mem_enable) begin
			busy <= 1'b1;
			owner_dm <= sel_dm;
		end
	end

endmodule

// ==== hw/cpu.sv ====
`timescale 1ns/1ps

module cpu (
	input  logic clk,
	input  logic rst,
	output logic mem_enable,
	output logic mem_rw,
	output logic [cpu_pkg::xlen-1:0] mem_addr,
	output logic [cpu_pkg::xlen-1:0] mem_wdata,
	input  logic mem_ack,
	input  logic [cpu_pkg::xlen-1:0] mem_rdata
);

	////////////////////
	// Signals
	////////////////////

	logic advance, pc_we, taken, load_stall, id_kill;
	logic if_busy, if_done, if_ack, dm_req, dm_ack, dm_done, mem_access;
	logic [cpu_pkg::xlen-1:0] pc, pc_plus4, next_pc, if_rdata, if_buf, if_instr;
	logic [cpu_pkg::xlen-1:0] dm_rdata, dm_buf;

	logic [cpu_pkg::xlen-1:0] id_instr, id_pc4, id_imm, rs_data, rt_data;
	logic [cpu_pkg::xlen-1:0] id_rs_val, id_rt_val;
	logic [4:0] id_dst;
	logic id_reg_write, id_reg_dst, id_alu_src, id_mem_read, id_mem_write;
	logic id_mem_to_reg, id_is_branch, id_is_jump, id_jump_reg, id_is_link;
	cpu_pkg::alu_op_t id_alu_op;
	cpu_pkg::fwd_sel_t fwd_rs, fwd_rt;

	logic ex_reg_write, ex_mem_read, ex_mem_write, ex_is_branch, ex_is_jump;
	logic ex_mem_to_reg, ex_jump_reg, ex_is_link, ex_alu_src, alu_zero;
	cpu_pkg::alu_op_t ex_alu_op;
	logic [cpu_pkg::xlen-1:0] ex_pc4, ex_rs_val, ex_rt_val, ex_imm;
	logic [cpu_pkg::xlen-1:0] alu_result, ex_result, branch_target, jump_target;
	logic [4:0] ex_dst, ex_shamt;
	logic [25:0] ex_index;

	logic mem_reg_write, mem_mem_read, mem_mem_write, mem_mem_to_reg;
	logic [cpu_pkg::xlen-1:0] mem_alu, mem_store, mem_result;
	logic [4:0] mem_dst;

	logic wb_reg_write;
	logic [cpu_pkg::xlen-1:0] wb_data;
	logic [4:0] wb_dst;

	////////////////////
	// Stall and flush
	////////////////////

	// Advance once the fetch and any data access have both completed
	assign mem_access = mem_mem_read | mem_mem_write;
	assign advance = (if_done | if_ack) & (~mem_access | dm_done | dm_ack);
	assign taken = ex_is_jump | (ex_is_branch & alu_zero);
	assign pc_we = advance & (taken | ~load_stall);
	assign id_kill = taken | load_stall;

	mem_arbiter u_arbiter (
		.clk(clk), .rst(rst),
		.if_req(if_busy), .if_addr(pc), .if_ack(if_ack), .if_rdata(if_rdata),
		.dm_req(dm_req), .dm_rw(mem_mem_read), .dm_addr(mem_alu), .dm_wdata(mem_store),
		.dm_ack(dm_ack), .dm_rdata(dm_rdata),
		.mem_enable(mem_enable), .mem_rw(mem_rw), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	////////////////////
	// Fetch
	////////////////////

	assign pc_plus4 = pc + 32'd4;
	assign next_pc = !taken ? pc_plus4 : ex_is_jump ? jump_target : branch_target;
	assign if_instr = if_done ? if_buf : if_rdata;

	// Fetch buffer holds the word across a stalled advance
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= cpu_pkg::reset_pc;
			if_busy <= 1'b0;
			if_done <= 1'b0;
		end else begin
			if (pc_we)
				pc <= next_pc;
			if_busy <= pc_we | (~if_ack & ~if_done);
			if_done <= ~pc_we & (if_done | if_ack);
		end
	end

	always_ff @(posedge clk) begin
		if (if_ack)
			if_buf <= if_rdata;
	end

	// IF/ID, an all-zero word is a bubble
	always_ff @(posedge clk) begin
		if (rst)
			id_instr <= '0;
		else if (pc_we)
			id_instr <= taken ? '0 : if_instr;
	end

	always_ff @(posedge clk) begin
		if (pc_we)
			id_pc4 <= pc_plus4;
	end

	////////////////////
	// Decode
	////////////////////

	control u_control (
		.opcode(id_instr[31:26]), .funct(id_instr[5:0]),
		.reg_write(id_reg_write), .reg_dst(id_reg_dst), .alu_src(id_alu_src),
		.mem_read(id_mem_read), .mem_write(id_mem_write), .mem_to_reg(id_mem_to_reg),
		.is_branch(id_is_branch), .is_jump(id_is_jump), .jump_reg(id_jump_reg),
		.is_link(id_is_link), .alu_op(id_alu_op)
	);

	regfile u_regfile (
		.clk(clk), .rst(rst),
		.rs_addr(id_instr[25:21]), .rt_addr(id_instr[20:16]),
		.rs_data(rs_data), .rt_data(rt_data),
		.wr_en(wb_reg_write), .wr_addr(wb_dst), .wr_data(wb_data)
	);

	hazard_unit u_hazard (
		.id_rs(id_instr[25:21]), .id_rt(id_instr[20:16]),
		.ex_dst(ex_dst), .mem_dst(mem_dst), .wb_dst(wb_dst),
		.ex_reg_write(ex_reg_write), .mem_reg_write(mem_reg_write),
		.wb_reg_write(wb_reg_write), .ex_mem_read(ex_mem_read),
		.fwd_rs(fwd_rs), .fwd_rt(fwd_rt), .load_stall(load_stall)
	);

	// ori zero-extends, everything else sign-extends
	assign id_imm = (id_instr[31:26] == cpu_pkg::op_ori) ? {16'h0, id_instr[15:0]} :
		{{16{id_instr[15]}}, id_instr[15:0]};
	assign id_dst = id_is_link ? 5'd31 : id_reg_dst ? id_instr[15:11] : id_instr[20:16];

	function automatic logic [cpu_pkg::xlen-1:0] fwd_pick(
		input cpu_pkg::fwd_sel_t sel,
		input logic [cpu_pkg::xlen-1:0] reg_val
	);
		case (sel)
			cpu_pkg::fwd_ex:  return ex_result;
			cpu_pkg::fwd_mem: return mem_result;
			cpu_pkg::fwd_wb:  return wb_data;
			default:          return reg_val;
		endcase
	endfunction

	always_comb begin
		id_rs_val = fwd_pick(fwd_rs, rs_data);
		id_rt_val = fwd_pick(fwd_rt, rt_data);
	end

	// ID/EX, side effects cleared on flush or load-use bubble
	always_ff @(posedge clk) begin
		if (rst) begin
			{ex_reg_write, ex_mem_read, ex_mem_write, ex_is_branch, ex_is_jump} <= '0;
		end else if (advance) begin
			ex_reg_write <= id_reg_write & ~id_kill;
			ex_mem_read <= id_mem_read & ~id_kill;
			ex_mem_write <= id_mem_write & ~id_kill;
			ex_is_branch <= id_is_branch & ~id_kill;
			ex_is_jump <= id_is_jump & ~id_kill;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			{ex_mem_to_reg, ex_jump_reg, ex_is_link, ex_alu_src} <=
				{id_mem_to_reg, id_jump_reg, id_is_link, id_alu_src};
			ex_alu_op <= id_alu_op;
			ex_pc4 <= id_pc4;
			ex_rs_val <= id_rs_val;
			ex_rt_val <= id_rt_val;
			ex_imm <= id_imm;
			ex_dst <= id_dst;
			ex_shamt <= id_instr[10:6];
			ex_index <= id_instr[25:0];
		end
	end

	////////////////////
	// Execute
	////////////////////

	alu u_alu (
		.op(ex_alu_op), .a(ex_rs_val), .b(ex_alu_src ? ex_imm : ex_rt_val),
		.shamt(ex_shamt), .result(alu_result), .zero(alu_zero)
	);

	assign branch_target = ex_pc4 + {ex_imm[29:0], 2'b00};
	assign jump_target = ex_jump_reg ? ex_rs_val : {ex_pc4[31:28], ex_index, 2'b00};
	// jal links to its own address plus 4
	assign ex_result = ex_is_link ? ex_pc4 : alu_result;

	always_ff @(posedge clk) begin
		if (rst)
			{mem_reg_write, mem_mem_read, mem_mem_write} <= '0;
		else if (advance)
			{mem_reg_write, mem_mem_read, mem_mem_write} <=
				{ex_reg_write, ex_mem_read, ex_mem_write};
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			mem_mem_to_reg <= ex_mem_to_reg;
			mem_alu <= ex_result;
			mem_store <= ex_rt_val;
			mem_dst <= ex_dst;
		end
	end

	////////////////////
	// Memory and write-back
	////////////////////

	assign dm_req = mem_access & ~dm_done;
	assign mem_result = !mem_mem_to_reg ? mem_alu : dm_done ? dm_buf : dm_rdata;

	always_ff @(posedge clk) begin
		if (rst)
			dm_done <= 1'b0;
		else
			dm_done <= ~advance & (dm_done | dm_ack);
	end

	always_ff @(posedge clk) begin
		if (dm_ack)
			dm_buf <= dm_rdata;
	end

	always_ff @(posedge clk) begin
		if (rst)
			wb_reg_write <= 1'b0;
		else if (advance)
			wb_reg_write <= mem_reg_write;
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			wb_data <= mem_result;
			wb_dst <= mem_dst;
		end
	end

endmodule

// ==== sim/cpu_chk.sv ====
`timescale 1ns/1ps

module cpu_chk (
	input logic clk,
	input logic rst,
	input logic mem_enable,
	input logic mem_rw,
	input logic [cpu_pkg::xlen-1:0] mem_addr,
	input logic [cpu_pkg::xlen-1:0] mem_wdata,
	input logic mem_ack
);

	// Number of failed properties, watched by the testbench
	int fail_count = 0;

	// Port idle in the first cycle after reset
	idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !mem_enable)
		else begin
			fail_count = fail_count + 1;
			$error("mem_enable high in the first cycle after reset");
		end

	// Request held steady until acknowledged
	request_held: assert property (@(posedge clk) disable iff (rst)
		mem_enable && !mem_ack |=> mem_enable && $stable(mem_rw) &&
			$stable(mem_addr) && $stable(mem_wdata))
		else begin
			fail_count = fail_count + 1;
			$error("memory request changed before mem_ack");
		end

	ack_needs_enable: assert property (@(posedge clk) disable iff (rst)
		mem_ack |-> mem_enable)
		else begin
			fail_count = fail_count + 1;
			$error("mem_ack seen without mem_enable");
		end

endmodule

bind cpu cpu_chk u_chk (
	.clk(clk),
	.rst(rst),
	.mem_enable(mem_enable),
	.mem_rw(mem_rw),
	.mem_addr(mem_addr),
	.mem_wdata(mem_wdata),
	.mem_ack(mem_ack)
);

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

	localparam int mem_words = 256;
	localparam int golden_words = 512;
	// Word index of the store count in the golden image
	localparam int store_base = 'h100;

	logic clk;
	logic rst;
	logic mem_enable;
	logic mem_rw;
	logic mem_ack;
	logic [cpu_pkg::xlen-1:0] mem_addr;
	logic [cpu_pkg::xlen-1:0] mem_wdata;
	logic [cpu_pkg::xlen-1:0] mem_rdata;

	logic [31:0] golden [golden_words];
	logic [31:0] mem [mem_words];
	int prog_len;
	int store_total;
	int store_idx;
	int delay_left;
	logic seeded;
	logic serving;
	logic loaded;

	cpu u_dut (
		.clk(clk), .rst(rst),
		.mem_enable(mem_enable), .mem_rw(mem_rw), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ack(mem_ack), .mem_rdata(mem_rdata)
	);

	always #50 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("mismatch %s expected %h got %h", name, expected, actual);
			$display("Test failures found");
			$fatal(1, "stopped on first error");
		end
	endtask

	// Compare one acknowledged store with the next expected pair
	task automatic record_store();
		if (store_idx >= store_total) begin
			$display("unexpected extra store to address %h", mem_addr);
			$display("Test failures found");
			$fatal(1, "stopped on first error");
		end
		check_value("mem_addr", golden[store_base + 1 + 2 * store_idx], mem_addr);
		check_value("mem_wdata", golden[store_base + 2 + 2 * store_idx], mem_wdata);
		mem[mem_addr[9:2]] = mem_wdata;
		store_idx = store_idx + 1;
	endtask

	////////////////////
	// Memory model
	////////////////////

	// Answers 1 to 4 cycles after a request shows up
	always @(posedge clk) begin
		if (rst) begin
			mem_ack <= 1'b0;
			serving = 1'b0;
		end else if (mem_ack) begin
			mem_ack <= 1'b0;
		end else if (mem_enable) begin
			if (!serving) begin
				serving = 1'b1;
				// First draw seeds the generator
				if (!seeded) begin
					seeded = 1'b1;
					delay_left = $urandom(60) % 4;
				end else begin
					delay_left = $urandom % 4;
				end
			end
			if (delay_left == 0) begin
				serving = 1'b0;
				mem_ack <= 1'b1;
				if (mem_rw)
					mem_rdata <= mem[mem_addr[9:2]];
				else
					record_store();
			end else begin
				delay_left = delay_left - 1;
			end
		end
	end

	////////////////////
	// Setup and end of run
	////////////////////

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		mem_ack = 1'b0;
		mem_rdata = '0;
		serving = 1'b0;
		seeded = 1'b0;
		delay_left = 0;
		store_idx = 0;
		loaded = 1'b0;
		for (int i = 0; i < golden_words; i++)
			golden[i] = '0;
		$readmemh("sim/cpu_golden.txt", golden);
		prog_len = 0;
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = golden[i];
			if (golden[i] != 0)
				prog_len = i + 1;
		end
		store_total = golden[store_base];
		if (prog_len == 0 || store_total == 0) begin
			$display("golden file has no program or no expected stores");
			$display("Test failures found");
			$fatal(1, "bad golden file");
		end
		loaded = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		wait (store_idx == store_total);
		// Let the bound checker see the last handshake
		repeat (2) @(posedge clk);
		if (u_dut.u_chk.fail_count == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("Test failures found");
			$fatal(1, "memory port assertion failed");
		end
	end

	always @(posedge clk) begin
		if (u_dut.u_chk.fail_count != 0) begin
			$display("a memory port handshake assertion failed");
			$display("Test failures found");
			$fatal(1, "stopped on first error");
		end
	end

	// Watchdog allows 40 cycles per instruction times 5 for slow memory
	initial begin
		wait (loaded);
		repeat (prog_len * 40 * 5) @(posedge clk);
		$display("timeout with only %0d of %0d expected stores seen", store_idx, store_total);
		$display("Test failures found");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== sim/cpu_golden.txt ====
// Words from 000: program image, four instruction words per line
// Words from 100: store count, then one store per line as address and data
@000
24010005 2402fffd 00221821 ac030200 // addiu addiu addu sw, forward from mem and ex
00222023 ac040204 3c051234 34a5ff0f // subu with wb forward, sw, lui, ori
ac050208 00a23024 ac06020c 00243825 // sw, and, sw, or
ac070210 0041402a 0022482a 00015100 // sw, slt true, slt false, sll by 4
ac080214 ac090218 ac0a021c 8c0b0208 // three sw, lw
01616021 ac0c0220 8c0d0204 ac0d0224 // load-use addu, sw, lw, load-use sw
10220002 ac010228 240e0077 10210002 // beq not taken, sw, addiu, beq taken
ac02022c ac020230 ac0e022c 08000022 // two flushed sw, sw, j 88
ac020230 ac020230 0c000026 ac1f0230 // two skipped sw, jal 98, sw of r31
08000029 ac020234 27ef0010 03e00008 // j a4, skipped sw, addiu from r31, jr
ac020234 ac0f0234 0800002a          // flushed sw, sw, self-jump
@100
0000000e
00000200 00000002
00000204 00000008
00000208 1234ff0f
0000020c 1234ff0d
00000210 0000000d
00000214 00000001
00000218 00000000
0000021c 00000050
00000220 1234ff14
00000224 00000008
00000228 00000005
0000022c 00000077
00000230 0000008c
00000234 0000009c

// ==== cpu.f ====
hw/cpu_pkg.sv
hw/alu.sv
hw/control.sv
hw/regfile.sv
hw/hazard_unit.sv
hw/mem_arbiter.sv
hw/cpu.sv
sim/cpu_chk.sv
sim/cpu_tb.sv
